// ==== Bender.yml ====
package:
  name: load_issue_bank

sources:
  - verilog/load_types_pkg.sv
  - verilog/issue_state_pkg.sv
  - verilog/entry_state_fsm.sv
  - verilog/occupancy_counter.sv
  - verilog/issue_picker.sv
  - verilog/payload_ram.sv
  - verilog/load_issue_bank.sv
  - target: test
    files:
      - tests/tb_load_issue_bank.sv

// ==== flist.f ====
verilog/load_types_pkg.sv
verilog/issue_state_pkg.sv
verilog/entry_state_fsm.sv
verilog/occupancy_counter.sv
verilog/issue_picker.sv
verilog/payload_ram.sv
verilog/load_issue_bank.sv
tests/tb_load_issue_bank.sv

// ==== tests/tb_load_issue_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_load_issue_bank;

    localparam int BANK_SIZE  = 8;
    localparam int WB_PORTS   = 2;
    localparam int IDX_W      = $clog2(BANK_SIZE);
    localparam int WAIT_LIMIT = 60;
    localparam int MIX_LOADS  = 24;
    localparam int MIX_LIMIT  = 1500;

    logic                                    clk;
    logic                                    rst;
    logic                                    dis_valid;
    logic                                    dis_ready;
    load_types_pkg::preg_t                   dis_rs1;
    logic                                    dis_rs1_ready;
    load_types_pkg::rob_idx_t                dis_rob_idx;
    load_types_pkg::lq_idx_t                 dis_lq_idx;
    load_types_pkg::preg_t                   dis_rd;
    load_types_pkg::imm_t                    dis_imm;
    load_types_pkg::size_t                   dis_size;
    logic [WB_PORTS-1:0]                     wb_valid;
    load_types_pkg::preg_t [WB_PORTS-1:0]    wb_preg;
    logic                                    issue_valid;
    logic                                    issue_ready;
    logic [IDX_W-1:0]                        issue_idx;
    load_types_pkg::rob_idx_t                issue_rob_idx;
    load_types_pkg::payload_t                issue_payload;
    logic                                    reply_valid;
    logic [IDX_W-1:0]                        reply_idx;
    logic                                    reply_replay;
    logic                                    redirect;
    load_types_pkg::rob_idx_t                redirect_rob_idx;

    // expected issues, indexed by lq index.
    load_types_pkg::payload_t   exp_pay [32];
    load_types_pkg::rob_idx_t   exp_rob [32];
    logic [31:0]                pending;

    logic [31:0] lcg;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    load_issue_bank #(
        .BANK_SIZE (BANK_SIZE),
        .WB_PORTS  (WB_PORTS)
    ) u_dut (
        .clk              (clk),
        .rst              (rst),
        .dis_valid        (dis_valid),
        .dis_ready        (dis_ready),
        .dis_rs1          (dis_rs1),
        .dis_rs1_ready    (dis_rs1_ready),
        .dis_rob_idx      (dis_rob_idx),
        .dis_lq_idx       (dis_lq_idx),
        .dis_rd           (dis_rd),
        .dis_imm          (dis_imm),
        .dis_size         (dis_size),
        .wb_valid         (wb_valid),
        .wb_preg          (wb_preg),
        .issue_valid      (issue_valid),
        .issue_ready      (issue_ready),
        .issue_idx        (issue_idx),
        .issue_rob_idx    (issue_rob_idx),
        .issue_payload    (issue_payload),
        .reply_valid      (reply_valid),
        .reply_idx        (reply_idx),
        .reply_replay     (reply_replay),
        .redirect         (redirect),
        .redirect_rob_idx (redirect_rob_idx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned rand_u(input int unsigned range);
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return (lcg >> 8) % range;
    endfunction

    // wrap-bit age rule, a older than b.
    function automatic logic older(input logic [5:0] a, input logic [5:0] b);
        if (a[5] == b[5]) begin
            return a[4:0] < b[4:0];
        end
        return a[4:0] > b[4:0];
    endfunction

    // falling edge, pulses drop back to idle.
    task automatic step();
        @(negedge clk);
        dis_valid   = 1'b0;
        wb_valid    = '0;
        issue_ready = 1'b0;
        reply_valid = 1'b0;
        redirect    = 1'b0;
    endtask

    task automatic timeout(input string name, input string what);
        $display("%s: timeout while waiting for %s", name, what);
        timed_out = 1'b1;
    endtask

    task automatic report(input string name, input int start);
        tests_run++;
        if (errors == start && !timed_out) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    task automatic drive_dispatch(input load_types_pkg::preg_t rs1, input logic rdy,
                                  input load_types_pkg::rob_idx_t rob,
                                  input load_types_pkg::lq_idx_t lq);
        load_types_pkg::preg_t rd;
        load_types_pkg::imm_t  imm;
        load_types_pkg::size_t sz;
        rd            = load_types_pkg::preg_t'(rand_u(64));
        imm           = load_types_pkg::imm_t'(rand_u(4096));
        sz            = load_types_pkg::size_t'(rand_u(4));
        dis_valid     = 1'b1;
        dis_rs1       = rs1;
        dis_rs1_ready = rdy;
        dis_rob_idx   = rob;
        dis_lq_idx    = lq;
        dis_rd        = rd;
        dis_imm       = imm;
        dis_size      = sz;
        exp_pay[lq]   = {imm, rd, lq, sz};   // imm, rd, lq, size.
        exp_rob[lq]   = rob;
        pending[lq]   = 1'b1;
    endtask

    task automatic dispatch(input string name, input int rs1, input logic rdy,
                            input int rob, input int lq);
        int n;
        n = 0;
        step();
        while (!dis_ready && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!dis_ready) begin
            timeout(name, "dis_ready");
        end else begin
            drive_dispatch(load_types_pkg::preg_t'(rs1), rdy,
                           load_types_pkg::rob_idx_t'(rob), load_types_pkg::lq_idx_t'(lq));
        end
    endtask

    task automatic wake(input logic [1:0] ports, input int p0, input int p1);
        step();
        wb_valid   = ports;
        wb_preg[0] = load_types_pkg::preg_t'(p0);
        wb_preg[1] = load_types_pkg::preg_t'(p1);
    endtask

    task automatic wait_valid(input string name);
        int n;
        n = 0;
        step();
        while (!issue_valid && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!issue_valid) begin
            timeout(name, "issue_valid");
        end
    endtask

    // handshake happens on the next rising edge.
    task automatic accept_issue(input string name, output load_types_pkg::payload_t pay,
                                output load_types_pkg::rob_idx_t rob,
                                output logic [IDX_W-1:0] idx);
        wait_valid(name);
        pay         = issue_payload;
        rob         = issue_rob_idx;
        idx         = issue_idx;
        issue_ready = !timed_out;
    endtask

    task automatic check_issue(input string name, input load_types_pkg::payload_t pay,
                               input load_types_pkg::rob_idx_t rob, input logic retire);
        int lq;
        lq = pay[6:2];
        assert (pending[lq]) else begin
            $display("%s: load with lq index %0d issued but was not expected", name, lq);
            errors++;
        end
        assert (pay == exp_pay[lq]) else begin
            $display("FAILED %s: expected payload %h, actual %h", name, exp_pay[lq], pay);
            errors++;
        end
        assert (rob == exp_rob[lq]) else begin
            $display("FAILED %s: expected rob %h, actual %h", name, exp_rob[lq], rob);
            errors++;
        end
        if (retire) begin
            pending[lq] = 1'b0;
        end
    endtask

    task automatic send_reply(input logic [IDX_W-1:0] idx, input logic replay);
        step();
        reply_valid  = 1'b1;
        reply_idx    = idx;
        reply_replay = replay;
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            step();
            assert (!issue_valid) else begin
                $display("%s: unexpected issue of rob %h", name, issue_rob_idx);
                errors++;
            end
        end
    endtask

    task automatic drain(input string name, input int n);
        load_types_pkg::payload_t pay;
        load_types_pkg::rob_idx_t rob;
        logic [IDX_W-1:0]         idx;
        repeat (n) begin
            accept_issue(name, pay, rob, idx);
            if (timed_out) return;
            check_issue(name, pay, rob, 1'b1);
            send_reply(idx, issue_state_pkg::REPLY_SUCCESS);
        end
    endtask

    task automatic basic_issue();
        load_types_pkg::payload_t pay;
        load_types_pkg::rob_idx_t rob;
        logic [IDX_W-1:0]         idx;
        int                       start;
        start = errors;
        assert (dis_ready && !issue_valid) else begin
            $display("basic_issue: bank not idle after reset");
            errors++;
        end
        dispatch("basic_issue", 3, 1'b1, 5, 1);
        accept_issue("basic_issue", pay, rob, idx);
        if (!timed_out) begin
            check_issue("basic_issue", pay, rob, 1'b1);
            send_reply(idx, issue_state_pkg::REPLY_SUCCESS);
        end
        report("basic_issue", start);
    endtask

    task automatic wakeup_issue();
        load_types_pkg::payload_t pay;
        load_types_pkg::rob_idx_t rob;
        logic [IDX_W-1:0]         idx;
        int                       start;
        start = errors;
        dispatch("wakeup_issue", 7, 1'b0, 6, 2);
        expect_quiet("wakeup_issue", 4);
        wake(2'b01, 8, 0);   // other preg.
        expect_quiet("wakeup_issue", 6);
        wake(2'b10, 0, 7);
        accept_issue("wakeup_issue", pay, rob, idx);
        if (!timed_out) begin
            check_issue("wakeup_issue", pay, rob, 1'b1);
            send_reply(idx, issue_state_pkg::REPLY_SUCCESS);
        end
        report("wakeup_issue", start);
    endtask

    task automatic full_bank();
        load_types_pkg::payload_t pay;
        load_types_pkg::rob_idx_t rob;
        logic [IDX_W-1:0]         idx;
        int                       start;
        start = errors;
        for (int i = 0; i < BANK_SIZE; i++) begin
            dispatch("full_bank", 10 + i, 1'b0, i, i);
        end
        step();
        assert (!dis_ready) else begin
            $display("FAILED full_bank: expected dis_ready 0, actual %b", dis_ready);
            errors++;
        end
        wake(2'b01, 13, 0);
        accept_issue("full_bank", pay, rob, idx);
        if (timed_out) return;
        check_issue("full_bank", pay, rob, 1'b1);
        send_reply(idx, issue_state_pkg::REPLY_SUCCESS);
        step();
        assert (dis_ready) else begin
            $display("FAILED full_bank: expected dis_ready 1, actual %b", dis_ready);
            errors++;
        end
        wake(2'b11, 10, 11);
        wake(2'b11, 12, 14);
        wake(2'b11, 15, 16);
        wake(2'b01, 17, 0);
        drain("full_bank", BANK_SIZE - 1);
        report("full_bank", start);
    endtask

    task automatic replay_issue();
        load_types_pkg::payload_t pay;
        load_types_pkg::rob_idx_t rob;
        logic [IDX_W-1:0]         idx;
        int                       start;
        start = errors;
        dispatch("replay_issue", 1, 1'b1, 9, 4);
        accept_issue("replay_issue", pay, rob, idx);
        if (timed_out) return;
        check_issue("replay_issue", pay, rob, 1'b0);
        send_reply(idx, issue_state_pkg::REPLY_REPLAY);
        drain("replay_issue", 1);   // same payload again.
        expect_quiet("replay_issue", 10);
        report("replay_issue", start);
    endtask

    task automatic redirect_flush();
        int robs [6];
        int start;
        start = errors;
        robs = '{28, 29, 30, 31, 32, 33};   // crosses the wrap.
        for (int i = 0; i < 6; i++) begin
            dispatch("redirect_flush", 20 + i, robs[i] == 32, robs[i], 10 + i);
        end
        wait_valid("redirect_flush");
        if (timed_out) return;
        redirect         = 1'b1;
        redirect_rob_idx = 6'd30;
        for (int i = 0; i < 6; i++) begin
            if (older(6'd30, 6'(robs[i]))) begin
                pending[10 + i] = 1'b0;
            end
        end
        step();
        assert (!issue_valid) else begin
            $display("redirect_flush: younger held issue was not squashed");
            errors++;
        end
        wake(2'b11, 20, 21);
        wake(2'b11, 22, 23);
        wake(2'b11, 24, 25);
        drain("redirect_flush", 3);
        expect_quiet("redirect_flush", 10);
        report("redirect_flush", start);
    endtask

    task automatic random_mix();
        load_types_pkg::payload_t held_pay;
        load_types_pkg::rob_idx_t held_rob;
        logic [IDX_W-1:0]         held_idx;
        logic                     held;
        int                       sent;
        int                       done;
        int                       cyc;
        int                       start;
        start = errors;
        sent  = 0;
        done  = 0;
        cyc   = 0;
        held  = 1'b0;
        while (done < MIX_LOADS && cyc < MIX_LIMIT) begin
            step();
            cyc++;
            if (held) begin
                assert (issue_valid && issue_payload == held_pay &&
                        issue_rob_idx == held_rob && issue_idx == held_idx) else begin
                    $display("FAILED random_mix: expected held %h, actual %h (valid %b)",
                             held_pay, issue_payload, issue_valid);
                    errors++;
                end
            end
            held = 1'b0;
            if (sent < MIX_LOADS && dis_ready && rand_u(2) == 0) begin
                drive_dispatch(load_types_pkg::preg_t'(40 + rand_u(8)), rand_u(3) == 0,
                               load_types_pkg::rob_idx_t'(sent), load_types_pkg::lq_idx_t'(sent));
                sent++;
            end
            if (rand_u(2) == 0) begin
                wb_valid[0] = 1'b1;
                wb_preg[0]  = load_types_pkg::preg_t'(40 + rand_u(8));
            end
            if (issue_valid) begin
                if (rand_u(3) == 0) begin
                    held     = 1'b1;   // back-pressure this cycle.
                    held_pay = issue_payload;
                    held_rob = issue_rob_idx;
                    held_idx = issue_idx;
                end else begin
                    check_issue("random_mix", issue_payload, issue_rob_idx, 1'b1);
                    issue_ready  = 1'b1;
                    reply_valid  = 1'b1;
                    reply_idx    = issue_idx;
                    reply_replay = issue_state_pkg::REPLY_SUCCESS;
                    done++;
                end
            end
        end
        if (done < MIX_LOADS) begin
            timeout("random_mix", "all loads to issue");
        end
        assert (pending == '0) else begin
            $display("FAILED random_mix: expected no pending loads, actual %h", pending);
            errors++;
        end
        report("random_mix", start);
    endtask

    initial begin
        rst              = 1'b1;
        dis_valid        = 1'b0;
        dis_rs1          = '0;
        dis_rs1_ready    = 1'b0;
        dis_rob_idx      = '0;
        dis_lq_idx       = '0;
        dis_rd           = '0;
        dis_imm          = '0;
        dis_size         = '0;
        wb_valid         = '0;
        wb_preg          = '0;
        issue_ready      = 1'b0;
        reply_valid      = 1'b0;
        reply_idx        = '0;
        reply_replay     = 1'b0;
        redirect         = 1'b0;
        redirect_rob_idx = '0;
        pending          = '0;
        lcg              = 32'd87;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        timed_out        = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        basic_issue();
        if (!timed_out) wakeup_issue();
        if (!timed_out) full_bank();
        if (!timed_out) replay_issue();
        if (!timed_out) redirect_flush();
        if (!timed_out) random_mix();
        $display("tests run %0d, tests failed %0d, check errors %0d, timeout %0d",
                 tests_run, tests_failed, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/entry_state_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module entry_state_fsm #(
    parameter int BANK_SIZE = 8,
    parameter int WB_PORTS  = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   alloc,
    input  wire logic [$clog2(BANK_SIZE)-1:0]           alloc_idx,
    input  wire load_types_pkg::preg_t                  alloc_rs1,
    input  wire logic                                   alloc_rs1_ready,
    input  wire load_types_pkg::rob_idx_t               alloc_rob,
    input  wire logic [WB_PORTS-1:0]                    wb_valid,
    input  wire load_types_pkg::preg_t [WB_PORTS-1:0]   wb_preg,
    input  wire logic                                   take,
    input  wire logic [$clog2(BANK_SIZE)-1:0]           take_idx,
    input  wire logic                                   reply_valid,
    input  wire logic [$clog2(BANK_SIZE)-1:0]           reply_idx,
    input  wire logic                                   reply_replay,
    input  wire logic                                   redirect,
    input  wire load_types_pkg::rob_idx_t               redirect_rob_idx,
    output logic [BANK_SIZE-1:0]                        ready,
    output logic [BANK_SIZE-1:0]                        occupied,
    output logic [BANK_SIZE-1:0]                        free_pulse,
    output load_types_pkg::rob_idx_t [BANK_SIZE-1:0]    entry_rob
);

    localparam int IDX_W = $clog2(BANK_SIZE);

    issue_state_pkg::entry_state_t state [BANK_SIZE];
    load_types_pkg::preg_t         rs1 [BANK_SIZE];

    logic [BANK_SIZE-1:0] fresh;   // allocated on the last edge.
    logic [BANK_SIZE-1:0] wake;
    logic [BANK_SIZE-1:0] alloc_hit;
    logic [BANK_SIZE-1:0] reply_hit;
    logic [BANK_SIZE-1:0] flush;
    logic                 alloc_wake;

    // wakeup in the same cycle as dispatch.
    always_comb begin
        alloc_wake = 1'b0;
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_valid[p] && wb_preg[p] == alloc_rs1) begin
                alloc_wake = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            wake[i] = 1'b0;
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_valid[p] && wb_preg[p] == rs1[i]) begin
                    wake[i] = 1'b1;
                end
            end
            alloc_hit[i] = alloc && (alloc_idx == IDX_W'(i));
            reply_hit[i] = reply_valid && (reply_idx == IDX_W'(i)) &&
                           (state[i] == issue_state_pkg::ENTRY_ISSUED);
            // an entry written this cycle is checked against its incoming rob index.
            if (alloc_hit[i]) begin
                flush[i] = redirect &&
                           load_types_pkg::rob_older(redirect_rob_idx, alloc_rob);
            end else begin
                flush[i] = redirect && (state[i] != issue_state_pkg::ENTRY_FREE) &&
                           load_types_pkg::rob_older(redirect_rob_idx, entry_rob[i]);
            end
            ready[i]      = (state[i] == issue_state_pkg::ENTRY_READY) && !fresh[i];
            occupied[i]   = (state[i] != issue_state_pkg::ENTRY_FREE);
            free_pulse[i] = flush[i] ||
                            (reply_hit[i] && reply_replay == issue_state_pkg::REPLY_SUCCESS);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                state[i] <= issue_state_pkg::ENTRY_FREE;
            end
            fresh <= '0;
        end else begin
            fresh <= alloc_hit;
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (flush[i]) begin
                    state[i] <= issue_state_pkg::ENTRY_FREE;   // redirect wins.
                end else if (alloc_hit[i]) begin
                    state[i] <= (alloc_rs1_ready || alloc_wake) ?
                                issue_state_pkg::ENTRY_READY : issue_state_pkg::ENTRY_WAIT;
                end else begin
                    case (state[i])
                        issue_state_pkg::ENTRY_WAIT: begin
                            if (wake[i]) begin
                                state[i] <= issue_state_pkg::ENTRY_READY;
                            end
                        end
                        issue_state_pkg::ENTRY_READY: begin
                            if (take && take_idx == IDX_W'(i)) begin
                                state[i] <= issue_state_pkg::ENTRY_ISSUED;
                            end
                        end
                        issue_state_pkg::ENTRY_ISSUED: begin
                            if (reply_hit[i]) begin
                                state[i] <= (reply_replay == issue_state_pkg::REPLY_REPLAY) ?
                                            issue_state_pkg::ENTRY_READY :
                                            issue_state_pkg::ENTRY_FREE;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rs1[alloc_idx]       <= alloc_rs1;
            entry_rob[alloc_idx] <= alloc_rob;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_picker.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_picker #(
    parameter int BANK_SIZE = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [BANK_SIZE-1:0]           ready,
    input  wire logic                           take,
    input  wire logic [BANK_SIZE-1:0]           occupied,
    output logic                                pick_valid,
    output logic [$clog2(BANK_SIZE)-1:0]        pick_idx,
    output logic [$clog2(BANK_SIZE)-1:0]        free_idx
);

    localparam int IDX_W = $clog2(BANK_SIZE);

    logic [IDX_W-1:0] ptr;   // highest priority slot.

    always_comb begin
        logic [IDX_W-1:0] cand;
        pick_valid = 1'b0;
        pick_idx   = ptr;
        for (int k = 0; k < BANK_SIZE; k++) begin
            cand = ptr + IDX_W'(k);   // wraps at the bank size.
            if (!pick_valid && ready[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    // lowest empty slot.
    always_comb begin
        free_idx = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (take) begin
            ptr <= pick_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_state_pkg.sv ====
`default_nettype none

package issue_state_pkg;

    typedef enum logic [1:0] {
        ENTRY_FREE   = 2'd0,
        ENTRY_WAIT   = 2'd1,   // waiting on rs1.
        ENTRY_READY  = 2'd2,
        ENTRY_ISSUED = 2'd3    // sent, waiting for the pipeline reply.
    } entry_state_t;

    // meaning of reply_replay.
    localparam logic REPLY_SUCCESS = 1'b0;
    localparam logic REPLY_REPLAY  = 1'b1;

endpackage

`default_nettype wire

// ==== verilog/load_issue_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_issue_bank #(
    parameter int BANK_SIZE = 8,
    parameter int WB_PORTS  = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   dis_valid,
    output logic                                        dis_ready,
    input  wire load_types_pkg::preg_t                  dis_rs1,
    input  wire logic                                   dis_rs1_ready,
    input  wire load_types_pkg::rob_idx_t               dis_rob_idx,
    input  wire load_types_pkg::lq_idx_t                dis_lq_idx,
    input  wire load_types_pkg::preg_t                  dis_rd,
    input  wire load_types_pkg::imm_t                   dis_imm,
    input  wire load_types_pkg::size_t                  dis_size,
    input  wire logic [WB_PORTS-1:0]                    wb_valid,
    input  wire load_types_pkg::preg_t [WB_PORTS-1:0]   wb_preg,
    output logic                                        issue_valid,
    input  wire logic                                   issue_ready,
    output logic [$clog2(BANK_SIZE)-1:0]                issue_idx,
    output load_types_pkg::rob_idx_t                    issue_rob_idx,
    output load_types_pkg::payload_t                    issue_payload,
    input  wire logic                                   reply_valid,
    input  wire logic [$clog2(BANK_SIZE)-1:0]           reply_idx,
    input  wire logic                                   reply_replay,
    input  wire logic                                   redirect,
    input  wire load_types_pkg::rob_idx_t               redirect_rob_idx
);

    localparam int IDX_W = $clog2(BANK_SIZE);
    localparam int CNT_W = $clog2(BANK_SIZE+1);

    logic                                       accept;
    logic                                       take;
    logic                                       full;
    logic [CNT_W-1:0]                           dec_count;
    logic [BANK_SIZE-1:0]                       ready;
    logic [BANK_SIZE-1:0]                       occupied;
    logic [BANK_SIZE-1:0]                       free_pulse;
    load_types_pkg::rob_idx_t [BANK_SIZE-1:0]   entry_rob;
    logic                                       pick_valid;
    logic [IDX_W-1:0]                           pick_idx;
    logic [IDX_W-1:0]                           free_idx;
    load_types_pkg::payload_t                   dis_payload;
    logic                                       squash;

    assign dis_ready   = !full;
    assign accept      = dis_valid && dis_ready;
    assign dis_payload = {dis_imm, dis_rd, dis_lq_idx, dis_size};

    // no new pick while a redirect is resolving.
    assign take = pick_valid && (!issue_valid || issue_ready) && !redirect;

    // held output younger than the redirect.
    assign squash = redirect && issue_valid &&
                    load_types_pkg::rob_older(redirect_rob_idx, issue_rob_idx);

    always_comb begin
        dec_count = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            dec_count = dec_count + CNT_W'(free_pulse[i]);
        end
    end

    entry_state_fsm #(
        .BANK_SIZE (BANK_SIZE),
        .WB_PORTS  (WB_PORTS)
    ) u_fsm (
        .clk              (clk),
        .rst              (rst),
        .alloc            (accept),
        .alloc_idx        (free_idx),
        .alloc_rs1        (dis_rs1),
        .alloc_rs1_ready  (dis_rs1_ready),
        .alloc_rob        (dis_rob_idx),
        .wb_valid         (wb_valid),
        .wb_preg          (wb_preg),
        .take             (take),
        .take_idx         (pick_idx),
        .reply_valid      (reply_valid),
        .reply_idx        (reply_idx),
        .reply_replay     (reply_replay),
        .redirect         (redirect),
        .redirect_rob_idx (redirect_rob_idx),
        .ready            (ready),
        .occupied         (occupied),
        .free_pulse       (free_pulse),
        .entry_rob        (entry_rob)
    );

    occupancy_counter #(
        .BANK_SIZE (BANK_SIZE)
    ) u_count (
        .clk       (clk),
        .rst       (rst),
        .inc       (accept),
        .dec_count (dec_count),
        .full      (full),
        .count     ()
    );

    issue_picker #(
        .BANK_SIZE (BANK_SIZE)
    ) u_picker (
        .clk        (clk),
        .rst        (rst),
        .ready      (ready),
        .take       (take),
        .occupied   (occupied),
        .pick_valid (pick_valid),
        .pick_idx   (pick_idx),
        .free_idx   (free_idx)
    );

    payload_ram #(
        .BANK_SIZE (BANK_SIZE)
    ) u_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (accept),
        .waddr (free_idx),
        .wdata (dis_payload),
        .re    (take),
        .raddr (pick_idx),
        .rdata (issue_payload)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (take) begin
            issue_valid <= 1'b1;
        end else if (squash || issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            issue_idx     <= pick_idx;
            issue_rob_idx <= entry_rob[pick_idx];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_types_pkg.sv ====
`default_nettype none

package load_types_pkg;

    localparam int PREG_W = 6;
    localparam int ROB_W  = 6;
    localparam int LQ_W   = 5;
    localparam int IMM_W  = 12;
    localparam int SIZE_W = 2;

    // imm, rd, lq index and access size, msb first.
    localparam int PAYLOAD_W = IMM_W + PREG_W + LQ_W + SIZE_W;

    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_W-1:0]     rob_idx_t;   // top bit is the wrap flag.
    typedef logic [LQ_W-1:0]      lq_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [SIZE_W-1:0]    size_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;

    // true when a is older than b in program order.
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        logic same_wrap;
        logic pos_less;
        logic pos_more;
        same_wrap = (a[ROB_W-1] == b[ROB_W-1]);
        pos_less  = (a[ROB_W-2:0] < b[ROB_W-2:0]);
        pos_more  = (a[ROB_W-2:0] > b[ROB_W-2:0]);
        if (same_wrap) begin
            return pos_less;
        end else begin
            return pos_more;   // b has wrapped past a.
        end
    endfunction

endpackage

`default_nettype wire

// ==== verilog/occupancy_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module occupancy_counter #(
    parameter int BANK_SIZE = 8
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               inc,
    input  wire logic [$clog2(BANK_SIZE+1)-1:0]     dec_count,
    output logic                                    full,
    output logic [$clog2(BANK_SIZE+1)-1:0]          count
);

    localparam int CNT_W = $clog2(BANK_SIZE+1);

    logic [CNT_W-1:0] count_next;

    // one alloc and any number of frees per cycle.
    assign count_next = count + CNT_W'(inc) - dec_count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    assign full = (count == CNT_W'(BANK_SIZE));

endmodule

`default_nettype wire

// ==== verilog/payload_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module payload_ram #(
    parameter int BANK_SIZE = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           we,
    input  wire logic [$clog2(BANK_SIZE)-1:0]   waddr,
    input  wire load_types_pkg::payload_t       wdata,
    input  wire logic                           re,
    input  wire logic [$clog2(BANK_SIZE)-1:0]   raddr,
    output load_types_pkg::payload_t            rdata
);

    load_types_pkg::payload_t mem [BANK_SIZE];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // holds the last read while re is low.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire
